// ==== include/fixdiv_consts.svh ====
`ifndef FIXDIV_CONSTS_SVH
`define FIXDIV_CONSTS_SVH

// operand and quotient width
`define FIXDIV_D_WIDTH 32

// fraction bits in the quotient
`define FIXDIV_Q_BITS 10

// working width, also the number of division steps
`define FIXDIV_ED_WIDTH (2 * `FIXDIV_D_WIDTH)

// entries per fifo
`define FIXDIV_FIFO_DEPTH 8

`endif

// ==== logic/fixdiv_pkg.sv ====
`default_nettype none

`include "fixdiv_consts.svh"

package fixdiv_pkg;

    typedef struct packed {
        logic signed [`FIXDIV_D_WIDTH-1:0] dividend;
        logic signed [`FIXDIV_D_WIDTH-1:0] divisor;
    } operand_pair_t;

    // Q_BITS of the width sit below the binary point
    typedef logic signed [`FIXDIV_D_WIDTH-1:0] quotient_t;

endpackage

`default_nettype wire

// ==== logic/fifo_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface fifo_if import fixdiv_pkg::*; #(
    parameter type payload_t = operand_pair_t
);

    logic     wr_en;
    payload_t din;
    logic     full;
    logic     rd_en;
    payload_t dout; // head entry, valid while empty is low
    logic     empty;

    modport producer (
        output wr_en,
        output din,
        input  full
    );

    modport consumer (
        output rd_en,
        input  dout,
        input  empty
    );

    modport fifo (
        input  wr_en,
        input  din,
        output full,
        input  rd_en,
        output dout,
        output empty
    );

endinterface

`default_nettype wire

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fixdiv_consts.svh"

module sync_fifo import fixdiv_pkg::*; #(
    parameter type payload_t = operand_pair_t,
    parameter int  depth     = `FIXDIV_FIFO_DEPTH
) (
    input logic  clock,
    input logic  reset,
    fifo_if.fifo fifo
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic             do_write;
    logic             do_read;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_write = fifo.wr_en && !fifo.full;
    assign do_read  = fifo.rd_en && !fifo.empty;

    assign fifo.empty = (count == '0);
    assign fifo.full  = (count == cnt_w'(depth));
    assign fifo.dout  = mem[rd_ptr]; // fall-through head

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= fifo.din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/fixed_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fixdiv_consts.svh"

module fixed_divider import fixdiv_pkg::*; (
    input logic      clock,
    input logic      reset,
    fifo_if.consumer operands,
    fifo_if.producer result
);

    localparam int dw     = `FIXDIV_D_WIDTH;
    localparam int qb     = `FIXDIV_Q_BITS;
    localparam int ew     = `FIXDIV_ED_WIDTH;
    localparam int step_w = $clog2(ew);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_write
    } state_t;

    state_t state;

    logic [step_w-1:0] step;

    operand_pair_t pair;
    logic [dw-1:0] dividend_mag;
    logic [dw-1:0] divisor_in_mag;
    logic [ew-1:0] load_value;
    logic          load;

    logic [ew:0]   rem_reg; // partial remainder, msb is its sign
    logic [ew-1:0] quo_reg; // dividend in, quotient out
    logic [dw-1:0] divisor_mag;
    logic          neg_dividend;
    logic          neg_divisor;

    logic [ew:0]   divisor_ext;
    logic [ew:0]   rem_shift;
    logic [ew:0]   rem_next;
    logic [ew-1:0] quo_next;

    quotient_t quo_low;

    assign pair = operands.dout;

    assign dividend_mag   = pair.dividend[dw-1] ? -pair.dividend : pair.dividend;
    assign divisor_in_mag = pair.divisor[dw-1] ? -pair.divisor : pair.divisor;

    // scale by 2^qb and add half the divisor so the result rounds
    assign load_value = (ew'(dividend_mag) << qb) + ew'(divisor_in_mag >> 1);

    assign load           = (state == st_idle) && !operands.empty;
    assign operands.rd_en = load;

    assign divisor_ext = (ew + 1)'(divisor_mag);

    // one non-restoring step
    always_comb begin
        rem_shift = {rem_reg[ew-1:0], quo_reg[ew-1]};
        if (rem_reg[ew]) begin
            rem_next = rem_shift + divisor_ext;
        end else begin
            rem_next = rem_shift - divisor_ext;
        end
        quo_next = {quo_reg[ew-2:0], ~rem_next[ew]};
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (!operands.empty) begin
                        state <= st_compute;
                        step  <= '0;
                    end
                end
                st_compute: begin
                    step <= step + 1'b1;
                    if (step == step_w'(ew - 1)) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    if (!result.full) begin
                        state <= st_idle; // leaves on the write edge
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            rem_reg      <= '0;
            quo_reg      <= load_value;
            divisor_mag  <= divisor_in_mag;
            neg_dividend <= pair.dividend[dw-1];
            neg_divisor  <= pair.divisor[dw-1];
        end else if (state == st_compute) begin
            rem_reg <= rem_next;
            quo_reg <= quo_next;
        end
    end

    // no overflow check, upper quotient bits are dropped
    assign quo_low = quo_reg[dw-1:0];

    assign result.din   = (neg_dividend ^ neg_divisor) ? -quo_low : quo_low;
    assign result.wr_en = (state == st_write) && !result.full;

endmodule

`default_nettype wire

// ==== logic/fixdiv_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fixdiv_consts.svh"

module fixdiv_top import fixdiv_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,

    input  logic                              in_wr_en,
    input  logic signed [`FIXDIV_D_WIDTH-1:0] in_dividend,
    input  logic signed [`FIXDIV_D_WIDTH-1:0] in_divisor,
    output logic                              in_full,

    input  logic                              out_rd_en,
    output quotient_t                         out_quotient,
    output logic                              out_empty
);

    fifo_if #(.payload_t(operand_pair_t)) in_fifo ();
    fifo_if #(.payload_t(quotient_t))     out_fifo ();

    // producer side of the operand fifo
    assign in_fifo.wr_en        = in_wr_en;
    assign in_fifo.din.dividend = in_dividend;
    assign in_fifo.din.divisor  = in_divisor;
    assign in_full              = in_fifo.full;

    // consumer side of the result fifo
    assign out_fifo.rd_en = out_rd_en;
    assign out_quotient   = out_fifo.dout;
    assign out_empty      = out_fifo.empty;

    sync_fifo #(
        .payload_t (operand_pair_t),
        .depth     (`FIXDIV_FIFO_DEPTH)
    ) u_in_fifo (
        .clock (clock),
        .reset (reset),
        .fifo  (in_fifo.fifo)
    );

    fixed_divider u_divider (
        .clock    (clock),
        .reset    (reset),
        .operands (in_fifo.consumer),
        .result   (out_fifo.producer)
    );

    sync_fifo #(
        .payload_t (quotient_t),
        .depth     (`FIXDIV_FIFO_DEPTH)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .fifo  (out_fifo.fifo)
    );

endmodule

`default_nettype wire

// ==== tb/clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
    parameter int half_period  = 2,
    parameter int reset_cycles = 5
) (
    input  logic reset_req, // extra reset from the testbench, for mid-run resets
    output logic clock,
    output logic reset
);

    logic por;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    initial begin
        por = 1'b1;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        por = 1'b0; // released away from the active edge
    end

    assign reset = por | reset_req;

endmodule

`default_nettype wire

// ==== tb/fixdiv_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module fixdiv_assertions (
    input logic clock,
    input logic reset,
    input logic in_wr_en,
    input logic in_full,
    input logic out_rd_en,
    input logic out_empty,
    input logic div_rd_en,
    input logic div_wr_en
);

    property no_push_when_full;
        @(posedge clock) disable iff (reset) in_wr_en |-> !in_full;
    endproperty

    property no_pop_when_empty;
        @(posedge clock) disable iff (reset) out_rd_en |-> !out_empty;
    endproperty

    // divider reads in idle and writes in write, never both
    property divider_one_side;
        @(posedge clock) disable iff (reset) !(div_rd_en && div_wr_en);
    endproperty

    property out_empty_known;
        @(posedge clock) disable iff (reset) !$isunknown(out_empty);
    endproperty

    a_no_push_when_full: assert property (no_push_when_full)
        else $error("operand fifo written while full");
    a_no_pop_when_empty: assert property (no_pop_when_empty)
        else $error("result fifo read while empty");
    a_divider_one_side: assert property (divider_one_side)
        else $error("divider read and write in the same cycle");
    a_out_empty_known: assert property (out_empty_known)
        else $error("out_empty unknown after reset");

endmodule

bind fixdiv_top fixdiv_assertions u_assertions (
    .clock     (clock),
    .reset     (reset),
    .in_wr_en  (in_wr_en),
    .in_full   (in_full),
    .out_rd_en (out_rd_en),
    .out_empty (out_empty),
    .div_rd_en (in_fifo.rd_en),
    .div_wr_en (out_fifo.wr_en)
);

`default_nettype wire

// ==== tb/fixdiv_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "fixdiv_consts.svh"

module fixdiv_tb import fixdiv_pkg::*; ();

    localparam int dw = `FIXDIV_D_WIDTH;
    localparam int qb = `FIXDIV_Q_BITS;

    localparam int total_pairs = 4 + 8 + 300 + 24 + 200 + 10 + 20;
    localparam int cycle_limit = total_pairs * 70 + 2000;
    localparam int hold_cycles = `FIXDIV_FIFO_DEPTH * 70; // long enough to fill the result fifo

    logic clock;
    logic reset;
    logic reset_req;

    logic              in_wr_en;
    logic signed [dw-1:0] in_dividend;
    logic signed [dw-1:0] in_divisor;
    logic              in_full;
    logic              out_rd_en;
    quotient_t         out_quotient;
    logic              out_empty;

    operand_pair_t stim_q[$];
    quotient_t     exp_q[$];

    int wr_pct = 100;
    int rd_pct = 100;
    int cycle_count = 0;

    clock_gen u_clock_gen (
        .reset_req (reset_req),
        .clock     (clock),
        .reset     (reset)
    );

    fixdiv_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .in_wr_en     (in_wr_en),
        .in_dividend  (in_dividend),
        .in_divisor   (in_divisor),
        .in_full      (in_full),
        .out_rd_en    (out_rd_en),
        .out_quotient (out_quotient),
        .out_empty    (out_empty)
    );

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [dw-1:0] actual,
                               input logic [dw-1:0] expected);
        if (actual !== expected) begin
            stop_on_failure($sformatf("ERROR %0t %s expected=%h actual=%h",
                                      $time, name, expected, actual));
        end
    endtask

    // rounded quotient at qb fraction bits in the low dw bits
    function automatic quotient_t expected_quotient(input operand_pair_t p);
        logic signed [63:0] a_s;
        logic signed [63:0] b_s;
        logic [63:0] a_mag;
        logic [63:0] b_mag;
        logic [63:0] num;
        logic [63:0] q_full;
        quotient_t q;
        a_s = p.dividend;
        b_s = p.divisor;
        a_mag = (a_s < 0) ? -a_s : a_s;
        b_mag = (b_s < 0) ? -b_s : b_s;
        num = (a_mag << qb) + (b_mag >> 1);
        q_full = num / b_mag;
        q = q_full[dw-1:0];
        if (p.dividend[dw-1] ^ p.divisor[dw-1]) begin
            q = -q;
        end
        return q;
    endfunction

    function automatic operand_pair_t make_pair(input int a, input int b);
        operand_pair_t p;
        p.dividend = a;
        p.divisor = b;
        return p;
    endfunction

    task automatic add_random_pairs(input int n);
        operand_pair_t p;
        for (int i = 0; i < n; i++) begin
            p.dividend = $urandom;
            p.divisor = $signed($urandom) >>> $urandom_range(30, 0); // spread of sizes
            if (p.divisor == 0) begin
                p.divisor = 1;
            end
            if (i % 50 == 0) begin
                p.dividend = 32'h8000_0000; // most negative
            end
            if (i % 75 == 37) begin
                p.divisor = 32'h8000_0000;
            end
            stim_q.push_back(p);
        end
    endtask

    // all four sign combinations of one pair of magnitudes
    task automatic add_sign_set(input int a, input int b, input int mag);
        check_value("model a/b", expected_quotient(make_pair(a, b)), mag);
        check_value("model -a/b", expected_quotient(make_pair(-a, b)), -mag);
        check_value("model a/-b", expected_quotient(make_pair(a, -b)), -mag);
        check_value("model -a/-b", expected_quotient(make_pair(-a, -b)), mag);
        stim_q.push_back(make_pair(a, b));
        stim_q.push_back(make_pair(-a, b));
        stim_q.push_back(make_pair(a, -b));
        stim_q.push_back(make_pair(-a, -b));
    endtask

    // one producer and consumer cycle on the falling edge
    task automatic step_cycle();
        operand_pair_t p;
        logic take;
        @(negedge clock);
        in_wr_en = 1'b0;
        if (stim_q.size() > 0 && !in_full && $urandom_range(99) < wr_pct) begin
            p = stim_q.pop_front();
            in_dividend = p.dividend;
            in_divisor = p.divisor;
            in_wr_en = 1'b1;
            exp_q.push_back(expected_quotient(p));
        end
        take = !out_empty && ($urandom_range(99) < rd_pct);
        out_rd_en = take;
        if (!out_empty && exp_q.size() == 0) begin
            stop_on_failure("a result came out with no pair waiting for it");
        end
        if (take) begin
            check_value("out_quotient", out_quotient, exp_q.pop_front());
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clock);
            in_wr_en = 1'b0;
            out_rd_en = 1'b0;
        end
    endtask

    task automatic run_until_done();
        while (stim_q.size() > 0 || exp_q.size() > 0) begin
            step_cycle();
        end
        idle_cycles(1);
        check_value("out_empty", dw'(out_empty), 1);
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset_req = 1'b1;
        in_wr_en = 1'b0;
        out_rd_en = 1'b0;
        stim_q.delete();
        exp_q.delete(); // anything in flight is lost
        repeat (3) @(negedge clock);
        reset_req = 1'b0;
        check_value("out_empty", dw'(out_empty), 1);
        check_value("in_full", dw'(in_full), 0);
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_on_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    initial begin
        reset_req = 1'b0;
        in_wr_en = 1'b0;
        in_dividend = '0;
        in_divisor = '0;
        out_rd_en = 1'b0;
        void'($urandom(81613));
        @(posedge clock);
        wait (reset == 1'b0);

        // exact cases against hand-worked values
        check_value("model 10/2", expected_quotient(make_pair(10, 2)), 5120);
        check_value("model 7/3", expected_quotient(make_pair(7, 3)), 2389);
        check_value("model 1/3", expected_quotient(make_pair(1, 3)), 341);
        check_value("model 100/7", expected_quotient(make_pair(100, 7)), 14629);
        stim_q.push_back(make_pair(10, 2));
        stim_q.push_back(make_pair(7, 3));
        stim_q.push_back(make_pair(1, 3));
        stim_q.push_back(make_pair(100, 7));
        run_until_done();

        add_sign_set(1000, 37, 27676);
        add_sign_set(123456, 789, 160227);
        run_until_done();

        add_random_pairs(300);
        run_until_done();

        // back-pressure with the consumer held off
        wr_pct = 100;
        rd_pct = 0;
        add_random_pairs(24);
        while (out_empty || !in_full) begin
            step_cycle();
        end
        repeat (hold_cycles) step_cycle();
        check_value("in_full", dw'(in_full), 1);
        rd_pct = 100;
        run_until_done();

        wr_pct = 50;
        rd_pct = 40;
        add_random_pairs(200);
        run_until_done();

        // reset while both fifos hold data
        wr_pct = 100;
        rd_pct = 0;
        add_random_pairs(10);
        repeat (100) step_cycle();
        apply_reset();
        rd_pct = 100;
        add_random_pairs(20);
        run_until_done();

        if (exp_q.size() != 0) begin
            stop_on_failure($sformatf("%0d expected results never came out", exp_q.size()));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
logic/fixdiv_pkg.sv
logic/fifo_if.sv
logic/sync_fifo.sv
logic/fixed_divider.sv
logic/fixdiv_top.sv
tb/clock_gen.sv
tb/fixdiv_assertions.sv
tb/fixdiv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= fixdiv_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
